//--- game_pkg.sv
`default_nettype none

package game_pkg;

    typedef logic [3:0] coord_t; // one grid column or row, 0 to 15

    localparam coord_t GRID_LAST = 4'd15; // last row and last column of the playfield
    localparam coord_t SHIP_ROW = 4'd15;  // the ship always sits on the bottom row

    // shots fly straight up and carry no drift
    typedef struct packed {
        logic   active;
        coord_t x;
        coord_t y;
    } shot_t;

    // drift is two's complement, so 2'b11 means one column left per step
    typedef struct packed {
        logic              active;
        coord_t            x;
        coord_t            y;
        logic signed [1:0] drift;
    } asteroid_t;

endpackage

`default_nettype wire

//--- object_table.sv
`timescale 1ns/1ps
`default_nettype none

module object_table #(
    parameter type entry_t = logic [7:0],
    parameter int DEPTH = 4,
    localparam int IW = $clog2(DEPTH)
) (
    input  wire logic    clock,
    input  wire logic    reset,
    input  wire logic    load,
    input  wire [IW-1:0] load_index,
    input  entry_t       load_entry,
    input  wire logic    move_write,
    input  wire [IW-1:0] move_index,
    input  entry_t       move_entry,
    input  wire logic    check_write,
    input  wire [IW-1:0] check_index,
    input  entry_t       check_entry,
    input  wire [IW-1:0] read_index_a,
    output entry_t       read_entry_a,
    input  wire [IW-1:0] read_index_b,
    output entry_t       read_entry_b,
    input  wire [IW-1:0] read_index_c,
    output entry_t       read_entry_c
);

    entry_t entries [DEPTH];

    // only one port writes per cycle, and a clash resolves in favour of the checker
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0; // all zero means inactive
            end
        end else if (check_write) begin
            entries[check_index] <= check_entry;
        end else if (move_write) begin
            entries[move_index] <= move_entry;
        end else if (load) begin
            entries[load_index] <= load_entry;
        end
    end

    assign read_entry_a = entries[read_index_a]; // mover port
    assign read_entry_b = entries[read_index_b]; // checker port
    assign read_entry_c = entries[read_index_c]; // external inspection port

endmodule

`default_nettype wire

//--- shot_mover.sv
`timescale 1ns/1ps
`default_nettype none

module shot_mover #(
    parameter int DEPTH = 4,
    localparam int IW = $clog2(DEPTH)
) (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      req,
    output logic           ack,
    output logic [IW-1:0]  read_index,
    input  game_pkg::shot_t read_entry,
    output logic           write,
    output logic [IW-1:0]  write_index,
    output game_pkg::shot_t write_entry
);

    logic          busy;
    logic [IW-1:0] index;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            ack   <= 1'b0;
            index <= '0;
        end else if (busy) begin
            index <= (index == IW'(DEPTH - 1)) ? '0 : index + 1'b1;
            if (index == IW'(DEPTH - 1)) begin
                busy <= 1'b0;
                ack  <= 1'b1; // last write lands on this edge
            end
        end else if (ack) begin
            ack <= req; // hold until the coordinator lets go
        end else if (req) begin
            busy  <= 1'b1;
            index <= '0;
        end
    end

    always_comb begin
        write_entry = read_entry;
        if (read_entry.active) begin
            if (read_entry.y == '0) begin
                write_entry.active = 1'b0; // leaves the top of the screen
            end else begin
                write_entry.y = read_entry.y - 1'b1;
            end
        end
    end

    assign read_index  = index;
    assign write_index = index;
    assign write       = busy; // one entry per cycle, inactive ones rewritten unchanged

endmodule

`default_nettype wire

//--- asteroid_mover.sv
`timescale 1ns/1ps
`default_nettype none

module asteroid_mover #(
    parameter int DEPTH = 4,
    localparam int IW = $clog2(DEPTH)
) (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          req,
    output logic               ack,
    output logic [IW-1:0]      read_index,
    input  game_pkg::asteroid_t read_entry,
    output logic               write,
    output logic [IW-1:0]      write_index,
    output game_pkg::asteroid_t write_entry
);

    import game_pkg::*;

    logic          busy;
    logic [IW-1:0] index;
    coord_t        drift_step; // drift widened to a full coordinate

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            ack   <= 1'b0;
            index <= '0;
        end else if (busy) begin
            index <= (index == IW'(DEPTH - 1)) ? '0 : index + 1'b1;
            if (index == IW'(DEPTH - 1)) begin
                busy <= 1'b0;
                ack  <= 1'b1;
            end
        end else if (ack) begin
            ack <= req;
        end else if (req) begin
            busy  <= 1'b1;
            index <= '0;
        end
    end

    assign drift_step = {{2{read_entry.drift[1]}}, read_entry.drift};

    always_comb begin
        write_entry = read_entry;
        if (read_entry.active) begin
            if (read_entry.y == GRID_LAST) begin
                write_entry.active = 1'b0; // falls off the bottom
            end else begin
                write_entry.y = read_entry.y + 1'b1;
                write_entry.x = read_entry.x + drift_step; // 4-bit add wraps the column
            end
        end
    end

    assign read_index  = index;
    assign write_index = index;
    assign write       = busy;

endmodule

`default_nettype wire

//--- collision_checker.sv
`timescale 1ns/1ps
`default_nettype none

module collision_checker #(
    parameter int SHOT_DEPTH = 4,
    parameter int ASTEROID_DEPTH = 4,
    localparam int SIW = $clog2(SHOT_DEPTH),
    localparam int AIW = $clog2(ASTEROID_DEPTH)
) (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           check_shots_req,
    output logic                check_shots_ack,
    input  wire logic           check_asteroids_req,
    output logic                check_asteroids_ack,
    input  game_pkg::coord_t    ship_x,
    output logic [SIW-1:0]      shot_read_index,
    input  game_pkg::shot_t     shot_read_entry,
    output logic                shot_write,
    output logic [SIW-1:0]      shot_write_index,
    output game_pkg::shot_t     shot_write_entry,
    output logic [AIW-1:0]      asteroid_read_index,
    input  game_pkg::asteroid_t asteroid_read_entry,
    output logic                asteroid_write,
    output logic [AIW-1:0]      asteroid_write_index,
    output game_pkg::asteroid_t asteroid_write_entry,
    output logic [7:0]          hits,
    output logic                ship_hit
);

    import game_pkg::*;

    logic           busy;
    logic           asteroid_mode; // set for the asteroid check, which adds the ship pass
    logic           ship_phase;    // first pass of asteroid mode, one asteroid per cycle
    logic [SIW-1:0] shot_index;
    logic [AIW-1:0] asteroid_index;
    logic           last_shot;
    logic           last_asteroid;
    logic           ship_match;
    logic           pair_match;

    assign last_shot     = (shot_index == SIW'(SHOT_DEPTH - 1));
    assign last_asteroid = (asteroid_index == AIW'(ASTEROID_DEPTH - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy                <= 1'b0;
            asteroid_mode       <= 1'b0;
            ship_phase          <= 1'b0;
            shot_index          <= '0;
            asteroid_index      <= '0;
            check_shots_ack     <= 1'b0;
            check_asteroids_ack <= 1'b0;
        end else if (busy) begin
            asteroid_index <= last_asteroid ? '0 : asteroid_index + 1'b1; // inner loop
            if (last_asteroid && ship_phase) begin
                ship_phase <= 1'b0; // ship pass over, pairs follow
            end else if (last_asteroid) begin
                shot_index <= last_shot ? '0 : shot_index + 1'b1;
                if (last_shot) begin
                    busy                <= 1'b0;
                    check_shots_ack     <= !asteroid_mode;
                    check_asteroids_ack <= asteroid_mode;
                end
            end
        end else if (check_shots_ack || check_asteroids_ack) begin
            check_shots_ack     <= check_shots_ack && check_shots_req;
            check_asteroids_ack <= check_asteroids_ack && check_asteroids_req;
        end else if (check_shots_req || check_asteroids_req) begin
            busy           <= 1'b1;
            asteroid_mode  <= !check_shots_req;
            ship_phase     <= !check_shots_req;
            shot_index     <= '0;
            asteroid_index <= '0;
        end
    end

    assign ship_match = busy && ship_phase && asteroid_read_entry.active &&
                        asteroid_read_entry.x == ship_x && asteroid_read_entry.y == SHIP_ROW;
    assign pair_match = busy && !ship_phase && shot_read_entry.active &&
                        asteroid_read_entry.active &&
                        shot_read_entry.x == asteroid_read_entry.x &&
                        shot_read_entry.y == asteroid_read_entry.y;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hits     <= 8'd0;
            ship_hit <= 1'b0;
        end else begin
            if (pair_match && hits != 8'hff) begin
                hits <= hits + 8'd1; // saturates at 255
            end
            if (ship_match) begin
                ship_hit <= 1'b1; // sticky until reset
            end
        end
    end

    // a match clears the entry in place and keeps its position bits
    always_comb begin
        shot_write_entry            = shot_read_entry;
        shot_write_entry.active     = 1'b0;
        asteroid_write_entry        = asteroid_read_entry;
        asteroid_write_entry.active = 1'b0;
    end

    assign shot_read_index      = shot_index;
    assign shot_write_index     = shot_index;
    assign asteroid_read_index  = asteroid_index;
    assign asteroid_write_index = asteroid_index;
    assign shot_write           = pair_match;
    assign asteroid_write       = pair_match || ship_match;

endmodule

`default_nettype wire

//--- update_coordinator.sv
`timescale 1ns/1ps
`default_nettype none

module update_coordinator #(
    parameter int SHOT_STEPS = 2,
    parameter int ASTEROID_STEPS = 1
) (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic update_req,
    output logic      update_ack,
    output logic      move_shots_req,
    input  wire logic move_shots_ack,
    output logic      move_asteroids_req,
    input  wire logic move_asteroids_ack,
    output logic      check_shots_req,
    input  wire logic check_shots_ack,
    output logic      check_asteroids_req,
    input  wire logic check_asteroids_ack
);

    localparam int SW = $clog2(SHOT_STEPS + 2);
    localparam int AW = $clog2(ASTEROID_STEPS + 2);

    // each worker call has a state that holds req and a release state that waits for ack to fall
    typedef enum logic [3:0] {
        IDLE,
        CLEAR,
        CHECK_SHOTS,
        CHECK_SHOTS_RELEASE,
        MOVE_SHOTS,
        MOVE_SHOTS_RELEASE,
        COUNT_SHOTS,
        CHECK_ASTEROIDS,
        CHECK_ASTEROIDS_RELEASE,
        MOVE_ASTEROIDS,
        MOVE_ASTEROIDS_RELEASE,
        COUNT_ASTEROIDS,
        DONE
    } state_t;

    state_t        state;
    state_t        next_state;
    logic [SW-1:0] shot_count;     // moves done in this frame's shot phase
    logic [AW-1:0] asteroid_count;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= IDLE;
            shot_count     <= '0;
            asteroid_count <= '0;
        end else begin
            state <= next_state;
            if (state == CLEAR) begin
                shot_count     <= '0;
                asteroid_count <= '0;
            end
            if (state == COUNT_SHOTS) begin
                shot_count <= shot_count + 1'b1;
            end
            if (state == COUNT_ASTEROIDS) begin
                asteroid_count <= asteroid_count + 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:                    if (update_req) next_state = CLEAR;
            CLEAR:                   next_state = CHECK_SHOTS;
            CHECK_SHOTS:             if (check_shots_ack) next_state = CHECK_SHOTS_RELEASE;
            CHECK_SHOTS_RELEASE:
                if (!check_shots_ack) begin
                    next_state = (shot_count == SW'(SHOT_STEPS)) ? CHECK_ASTEROIDS : MOVE_SHOTS;
                end
            MOVE_SHOTS:              if (move_shots_ack) next_state = MOVE_SHOTS_RELEASE;
            MOVE_SHOTS_RELEASE:      if (!move_shots_ack) next_state = COUNT_SHOTS;
            COUNT_SHOTS:             next_state = CHECK_SHOTS;
            CHECK_ASTEROIDS:         if (check_asteroids_ack) next_state = CHECK_ASTEROIDS_RELEASE;
            CHECK_ASTEROIDS_RELEASE:
                if (!check_asteroids_ack) begin
                    next_state = (asteroid_count == AW'(ASTEROID_STEPS)) ? DONE : MOVE_ASTEROIDS;
                end
            MOVE_ASTEROIDS:          if (move_asteroids_ack) next_state = MOVE_ASTEROIDS_RELEASE;
            MOVE_ASTEROIDS_RELEASE:  if (!move_asteroids_ack) next_state = COUNT_ASTEROIDS;
            COUNT_ASTEROIDS:         next_state = CHECK_ASTEROIDS;
            DONE:                    if (!update_req) next_state = IDLE; // ack drops a cycle later
            default:                 next_state = IDLE;
        endcase
    end

    // moore outputs, so only one worker req can be high at a time
    assign check_shots_req     = (state == CHECK_SHOTS);
    assign move_shots_req      = (state == MOVE_SHOTS);
    assign check_asteroids_req = (state == CHECK_ASTEROIDS);
    assign move_asteroids_req  = (state == MOVE_ASTEROIDS);
    assign update_ack          = (state == DONE);

endmodule

`default_nettype wire

//--- asteroid_update_top.sv
`timescale 1ns/1ps
`default_nettype none

module asteroid_update_top #(
    parameter int SHOT_DEPTH = 4,
    parameter int ASTEROID_DEPTH = 4,
    parameter int SHOT_STEPS = 2,
    parameter int ASTEROID_STEPS = 1,
    localparam int SIW = $clog2(SHOT_DEPTH),
    localparam int AIW = $clog2(ASTEROID_DEPTH)
) (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           update_req,
    output logic                update_ack,
    input  game_pkg::coord_t    ship_x,
    input  wire logic           shot_load,
    input  wire [SIW-1:0]       shot_load_index,
    input  game_pkg::shot_t     shot_load_entry,
    input  wire logic           asteroid_load,
    input  wire [AIW-1:0]       asteroid_load_index,
    input  game_pkg::asteroid_t asteroid_load_entry,
    input  wire [SIW-1:0]       shot_read_index,
    output game_pkg::shot_t     shot_read_entry,
    input  wire [AIW-1:0]       asteroid_read_index,
    output game_pkg::asteroid_t asteroid_read_entry,
    output logic [7:0]          hits,
    output logic                ship_hit
);

    import game_pkg::*;

    logic           move_shots_req, move_shots_ack, move_asteroids_req, move_asteroids_ack;
    logic           check_shots_req, check_shots_ack, check_asteroids_req, check_asteroids_ack;
    logic [SIW-1:0] sm_read_index, sm_write_index, sc_read_index, sc_write_index;
    logic [AIW-1:0] am_read_index, am_write_index, ac_read_index, ac_write_index;
    logic           sm_write, sc_write, am_write, ac_write;
    shot_t          sm_read_entry, sm_write_entry, sc_read_entry, sc_write_entry;
    asteroid_t      am_read_entry, am_write_entry, ac_read_entry, ac_write_entry;

    update_coordinator #(.SHOT_STEPS(SHOT_STEPS), .ASTEROID_STEPS(ASTEROID_STEPS)) coordinator (
        .clock, .reset, .update_req, .update_ack,
        .move_shots_req, .move_shots_ack, .move_asteroids_req, .move_asteroids_ack,
        .check_shots_req, .check_shots_ack, .check_asteroids_req, .check_asteroids_ack
    );

    object_table #(.entry_t(shot_t), .DEPTH(SHOT_DEPTH)) shot_table (
        .clock, .reset,
        .load(shot_load), .load_index(shot_load_index), .load_entry(shot_load_entry),
        .move_write(sm_write), .move_index(sm_write_index), .move_entry(sm_write_entry),
        .check_write(sc_write), .check_index(sc_write_index), .check_entry(sc_write_entry),
        .read_index_a(sm_read_index), .read_entry_a(sm_read_entry),
        .read_index_b(sc_read_index), .read_entry_b(sc_read_entry),
        .read_index_c(shot_read_index), .read_entry_c(shot_read_entry)
    );

    object_table #(.entry_t(asteroid_t), .DEPTH(ASTEROID_DEPTH)) asteroid_table (
        .clock, .reset,
        .load(asteroid_load), .load_index(asteroid_load_index),
        .load_entry(asteroid_load_entry),
        .move_write(am_write), .move_index(am_write_index), .move_entry(am_write_entry),
        .check_write(ac_write), .check_index(ac_write_index), .check_entry(ac_write_entry),
        .read_index_a(am_read_index), .read_entry_a(am_read_entry),
        .read_index_b(ac_read_index), .read_entry_b(ac_read_entry),
        .read_index_c(asteroid_read_index), .read_entry_c(asteroid_read_entry)
    );

    shot_mover #(.DEPTH(SHOT_DEPTH)) shot_move (
        .clock, .reset, .req(move_shots_req), .ack(move_shots_ack),
        .read_index(sm_read_index), .read_entry(sm_read_entry),
        .write(sm_write), .write_index(sm_write_index), .write_entry(sm_write_entry)
    );

    asteroid_mover #(.DEPTH(ASTEROID_DEPTH)) asteroid_move (
        .clock, .reset, .req(move_asteroids_req), .ack(move_asteroids_ack),
        .read_index(am_read_index), .read_entry(am_read_entry),
        .write(am_write), .write_index(am_write_index), .write_entry(am_write_entry)
    );

    collision_checker #(.SHOT_DEPTH(SHOT_DEPTH), .ASTEROID_DEPTH(ASTEROID_DEPTH)) collision_check (
        .clock, .reset,
        .check_shots_req, .check_shots_ack, .check_asteroids_req, .check_asteroids_ack,
        .ship_x,
        .shot_read_index(sc_read_index), .shot_read_entry(sc_read_entry),
        .shot_write(sc_write), .shot_write_index(sc_write_index),
        .shot_write_entry(sc_write_entry),
        .asteroid_read_index(ac_read_index), .asteroid_read_entry(ac_read_entry),
        .asteroid_write(ac_write), .asteroid_write_index(ac_write_index),
        .asteroid_write_entry(ac_write_entry),
        .hits, .ship_hit
    );

endmodule

`default_nettype wire

//--- asteroid_update_properties.sv
`timescale 1ns/1ps
`default_nettype none

module asteroid_update_properties (
    input wire logic clock,
    input wire logic reset,
    input wire logic update_req,
    input wire logic update_ack,
    input wire logic move_shots_req,
    input wire logic move_shots_ack,
    input wire logic move_asteroids_req,
    input wire logic move_asteroids_ack,
    input wire logic check_shots_req,
    input wire logic check_shots_ack,
    input wire logic check_asteroids_req,
    input wire logic check_asteroids_ack
);

    // an ack may only answer a request that is still raised
    update_ack_rise: assert property (@(posedge clock) disable iff (reset)
        $rose(update_ack) |-> update_req) else $error("update_ack rose without update_req");
    move_shots_ack_rise: assert property (@(posedge clock) disable iff (reset)
        $rose(move_shots_ack) |-> move_shots_req) else $error("move_shots_ack without req");
    move_asteroids_ack_rise: assert property (@(posedge clock) disable iff (reset)
        $rose(move_asteroids_ack) |-> move_asteroids_req)
        else $error("move_asteroids_ack without req");
    check_shots_ack_rise: assert property (@(posedge clock) disable iff (reset)
        $rose(check_shots_ack) |-> check_shots_req) else $error("check_shots_ack without req");
    check_asteroids_ack_rise: assert property (@(posedge clock) disable iff (reset)
        $rose(check_asteroids_ack) |-> check_asteroids_req)
        else $error("check_asteroids_ack without req");

    move_shots_req_hold: assert property (@(posedge clock) disable iff (reset)
        move_shots_req && !move_shots_ack |=> move_shots_req)
        else $error("move_shots_req dropped before ack");
    move_asteroids_req_hold: assert property (@(posedge clock) disable iff (reset)
        move_asteroids_req && !move_asteroids_ack |=> move_asteroids_req)
        else $error("move_asteroids_req dropped before ack");
    check_shots_req_hold: assert property (@(posedge clock) disable iff (reset)
        check_shots_req && !check_shots_ack |=> check_shots_req)
        else $error("check_shots_req dropped before ack");
    check_asteroids_req_hold: assert property (@(posedge clock) disable iff (reset)
        check_asteroids_req && !check_asteroids_ack |=> check_asteroids_req)
        else $error("check_asteroids_req dropped before ack");

    // table write ports are shared, so only one worker may run at a time
    worker_req_exclusive: assert property (@(posedge clock) disable iff (reset)
        $onehot0({move_shots_req, move_asteroids_req, check_shots_req, check_asteroids_req}))
        else $error("two worker requests are high together");

    update_ack_in_reset: assert property (@(posedge clock) reset |-> !update_ack)
        else $error("update_ack is high during reset");

endmodule

bind update_coordinator asteroid_update_properties props0 (.*);

`default_nettype wire

//--- tb_asteroid_update.sv
`timescale 1ns/1ps
`default_nettype none

module tb_asteroid_update;

    import game_pkg::*;

    localparam int SHOT_DEPTH = 4;
    localparam int ASTEROID_DEPTH = 4;
    localparam int SHOT_STEPS = 2;
    localparam int ASTEROID_STEPS = 1;
    localparam int SIW = $clog2(SHOT_DEPTH);
    localparam int AIW = $clog2(ASTEROID_DEPTH);
    localparam int FRAMES = 24; // four directed frames and twenty random ones
    // worst case work of one frame plus about eight cycles of handshake per worker call
    localparam int FRAME_CYCLES = (SHOT_STEPS + 1) * SHOT_DEPTH * ASTEROID_DEPTH
        + SHOT_STEPS * SHOT_DEPTH + ASTEROID_STEPS * ASTEROID_DEPTH
        + (ASTEROID_STEPS + 1) * ASTEROID_DEPTH * (SHOT_DEPTH + 1)
        + 8 * (2 * SHOT_STEPS + 2 * ASTEROID_STEPS + 2);
    localparam int SCENE_CYCLES = 5 * (SHOT_DEPTH + ASTEROID_DEPTH) + 10; // loads and reads
    localparam int WATCHDOG_NS = 2 * FRAMES * (FRAME_CYCLES + SCENE_CYCLES) * 8;

    logic           clock;
    logic           reset;
    logic           update_req;
    logic           update_ack;
    coord_t         ship_x;
    logic           shot_load;
    logic [SIW-1:0] shot_load_index;
    shot_t          shot_load_entry;
    logic           asteroid_load;
    logic [AIW-1:0] asteroid_load_index;
    asteroid_t      asteroid_load_entry;
    logic [SIW-1:0] shot_read_index;
    shot_t          shot_read_entry;
    logic [AIW-1:0] asteroid_read_index;
    asteroid_t      asteroid_read_entry;
    logic [7:0]     hits;
    logic           ship_hit;

    shot_t       model_shots [SHOT_DEPTH];
    asteroid_t   model_asteroids [ASTEROID_DEPTH];
    int          model_hits;
    logic        model_ship_hit;
    int          errors;
    int          frames_run;
    logic [31:0] rng;

    asteroid_update_top #(
        .SHOT_DEPTH(SHOT_DEPTH), .ASTEROID_DEPTH(ASTEROID_DEPTH),
        .SHOT_STEPS(SHOT_STEPS), .ASTEROID_STEPS(ASTEROID_STEPS)
    ) dut0 (
        .clock, .reset, .update_req, .update_ack, .ship_x,
        .shot_load, .shot_load_index, .shot_load_entry,
        .asteroid_load, .asteroid_load_index, .asteroid_load_entry,
        .shot_read_index, .shot_read_entry, .asteroid_read_index, .asteroid_read_entry,
        .hits, .ship_hit
    );

    always #4 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("FAIL %s %s expected %h actual %h", name, what, expected, actual);
        errors++;
    endtask

    // pairs are walked shot by shot, so an earlier match hides an entry from later pairs
    task automatic model_check_pairs();
        for (int i = 0; i < SHOT_DEPTH; i++) begin
            for (int j = 0; j < ASTEROID_DEPTH; j++) begin
                if (model_shots[i].active && model_asteroids[j].active &&
                    model_shots[i].x == model_asteroids[j].x &&
                    model_shots[i].y == model_asteroids[j].y) begin
                    model_shots[i].active = 1'b0;
                    model_asteroids[j].active = 1'b0;
                    if (model_hits < 255) begin
                        model_hits++;
                    end
                end
            end
        end
    endtask

    task automatic model_check_ship();
        for (int j = 0; j < ASTEROID_DEPTH; j++) begin
            if (model_asteroids[j].active && model_asteroids[j].x == ship_x &&
                model_asteroids[j].y == SHIP_ROW) begin
                model_asteroids[j].active = 1'b0;
                model_ship_hit = 1'b1;
            end
        end
    endtask

    task automatic model_move_shots();
        for (int i = 0; i < SHOT_DEPTH; i++) begin
            if (model_shots[i].active && model_shots[i].y == 4'd0) begin
                model_shots[i].active = 1'b0;
            end else if (model_shots[i].active) begin
                model_shots[i].y = model_shots[i].y - 4'd1;
            end
        end
    endtask

    task automatic model_move_asteroids();
        for (int j = 0; j < ASTEROID_DEPTH; j++) begin
            if (model_asteroids[j].active && model_asteroids[j].y == GRID_LAST) begin
                model_asteroids[j].active = 1'b0;
            end else if (model_asteroids[j].active) begin
                model_asteroids[j].y = model_asteroids[j].y + 4'd1;
                if (model_asteroids[j].drift == 2'b01) begin
                    model_asteroids[j].x = model_asteroids[j].x + 4'd1; // wraps past 15
                end else if (model_asteroids[j].drift == 2'b11) begin
                    model_asteroids[j].x = model_asteroids[j].x - 4'd1;
                end
            end
        end
    endtask

    task automatic model_frame();
        for (int s = 0; s <= SHOT_STEPS; s++) begin
            model_check_pairs();
            if (s < SHOT_STEPS) begin
                model_move_shots();
            end
        end
        for (int a = 0; a <= ASTEROID_STEPS; a++) begin
            model_check_ship(); // the ship is tested before any pair
            model_check_pairs();
            if (a < ASTEROID_STEPS) begin
                model_move_asteroids();
            end
        end
    endtask

    task automatic load_shot(input int index, input shot_t entry);
        @(posedge clock);
        #1;
        shot_load = 1'b1;
        shot_load_index = SIW'(index);
        shot_load_entry = entry;
        model_shots[index] = entry;
        @(posedge clock);
        #1;
        shot_load = 1'b0;
    endtask

    task automatic load_asteroid(input int index, input asteroid_t entry);
        @(posedge clock);
        #1;
        asteroid_load = 1'b1;
        asteroid_load_index = AIW'(index);
        asteroid_load_entry = entry;
        model_asteroids[index] = entry;
        @(posedge clock);
        #1;
        asteroid_load = 1'b0;
    endtask

    task automatic clear_tables();
        for (int i = 0; i < SHOT_DEPTH; i++) begin
            load_shot(i, '0);
        end
        for (int j = 0; j < ASTEROID_DEPTH; j++) begin
            load_asteroid(j, '0);
        end
    endtask

    task automatic compare_all(input string name);
        for (int i = 0; i < SHOT_DEPTH; i++) begin
            @(posedge clock);
            #1;
            shot_read_index = SIW'(i);
            @(negedge clock);
            assert (shot_read_entry == model_shots[i])
                else report_mismatch(name, $sformatf("shot[%0d]", i),
                                     32'(model_shots[i]), 32'(shot_read_entry));
        end
        for (int j = 0; j < ASTEROID_DEPTH; j++) begin
            @(posedge clock);
            #1;
            asteroid_read_index = AIW'(j);
            @(negedge clock);
            assert (asteroid_read_entry == model_asteroids[j])
                else report_mismatch(name, $sformatf("asteroid[%0d]", j),
                                     32'(model_asteroids[j]), 32'(asteroid_read_entry));
        end
        assert (hits == 8'(model_hits))
            else report_mismatch(name, "hits", 32'(model_hits), 32'(hits));
        assert (ship_hit == model_ship_hit)
            else report_mismatch(name, "ship_hit", 32'(model_ship_hit), 32'(ship_hit));
    endtask

    task automatic wait_update_ack(input logic level, input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (update_ack !== level && cycles < FRAME_CYCLES);
        if (update_ack !== level) begin
            $display("%s: update_ack did not go to %b within %0d cycles", name, level, cycles);
            errors++;
        end
    endtask

    // one full four-phase update, then the model runs the same frame and both are compared
    task automatic run_frame(input string name);
        @(posedge clock);
        #1;
        update_req = 1'b1;
        wait_update_ack(1'b1, name);
        @(posedge clock);
        #1;
        update_req = 1'b0;
        wait_update_ack(1'b0, name);
        model_frame();
        compare_all(name);
        frames_run++;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the frames did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        update_req = 1'b0;
        ship_x = 4'd2;
        shot_load = 1'b0;
        shot_load_index = '0;
        shot_load_entry = '0;
        asteroid_load = 1'b0;
        asteroid_load_index = '0;
        asteroid_load_entry = '0;
        shot_read_index = '0;
        asteroid_read_index = '0;
        model_shots = '{default: '0};
        model_asteroids = '{default: '0};
        model_hits = 0;
        model_ship_hit = 1'b0;
        errors = 0;
        frames_run = 0;
        rng = 32'h7192_3b65;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        compare_all("reset");
        assert (update_ack == 1'b0)
            else report_mismatch("reset", "update_ack", 32'd0, 32'(update_ack));

        // row 1 and row 0 shots leave the screen within the frame
        load_shot(0, shot_t'{1'b1, 4'd3, 4'd10});
        load_shot(1, shot_t'{1'b1, 4'd7, 4'd1});
        load_shot(2, shot_t'{1'b1, 4'd12, 4'd0});
        run_frame("lone_shots");

        clear_tables();
        load_asteroid(0, asteroid_t'{1'b1, 4'd5, 4'd4, 2'b01});
        load_asteroid(1, asteroid_t'{1'b1, 4'd15, 4'd7, 2'b01});
        load_asteroid(2, asteroid_t'{1'b1, 4'd0, 4'd2, 2'b11});
        load_asteroid(3, asteroid_t'{1'b1, 4'd9, 4'd15, 2'b00});
        run_frame("lone_asteroids");

        // the shot climbs two rows onto the asteroid for the last shot check
        clear_tables();
        load_shot(1, shot_t'{1'b1, 4'd6, 4'd8});
        load_asteroid(2, asteroid_t'{1'b1, 4'd6, 4'd6, 2'b00});
        run_frame("shot_meets_asteroid");

        clear_tables();
        ship_x = 4'd4;
        load_asteroid(0, asteroid_t'{1'b1, 4'd3, 4'd14, 2'b01});
        run_frame("ship_hit");

        for (int f = 0; f < FRAMES - 4; f++) begin
            for (int i = 0; i < SHOT_DEPTH; i++) begin
                rng = xorshift32(rng);
                load_shot(i, shot_t'{rng[8], {2'b01, rng[1:0]}, rng[7:4]});
            end
            for (int j = 0; j < ASTEROID_DEPTH; j++) begin
                rng = xorshift32(rng);
                load_asteroid(j, asteroid_t'{rng[8], {2'b01, rng[1:0]}, rng[7:4],
                                             (rng[13:12] == 2'b10) ? 2'b00 : rng[13:12]});
            end
            rng = xorshift32(rng);
            ship_x = {2'b01, rng[1:0]}; // same narrow column band as the objects
            run_frame($sformatf("random_%0d", f));
        end

        $display("frames run: %0d, errors: %0d", frames_run, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
game_pkg.sv
object_table.sv
shot_mover.sv
asteroid_mover.sv
collision_checker.sv
update_coordinator.sv
asteroid_update_top.sv
asteroid_update_properties.sv
tb_asteroid_update.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_asteroid_update
FILELIST  = tb.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(BUILD_DIR)
